/* common/keypad_display_pkg.sv */
`default_nettype none

package keypad_display_pkg;

        // divider bits pacing the scan, debounce and digit ticks
        localparam int SCAN_DIV_BIT     = 3;
        localparam int DEBOUNCE_DIV_BIT = 2;
        localparam int DIGIT_DIV_BIT    = 4;
        localparam int DIV_WIDTH        = 8;

        typedef enum logic [4:0] {
                SCAN0       = 5'b00001,
                SCAN1       = 5'b00010,
                SCAN2       = 5'b00100,
                SCAN3       = 5'b01000,
                KEY_PROCESS = 5'b10000
        } scan_state_t;

        typedef struct packed {
                logic rise;
                logic fall;
        } tick_t;

        typedef struct packed {
                logic       valid;
                logic [3:0] code;
        } key_event_t;

        // com and seg are both active low, seg ordered dp g f e d c b a
        typedef struct packed {
                logic [3:0] com;
                logic [7:0] seg;
        } fnd_t;

        // telephone style layout, one nibble per row, row 0 in the low nibble
        function automatic logic [3:0] key_code(input logic [1:0] c, input logic [1:0] r);
                logic [15:0] map;
                case (c)
                        2'd0:    map = 16'hC147;
                        2'd1:    map = 16'h0258;
                        2'd2:    map = 16'hF369;
                        default: map = 16'hDEBA;
                endcase
                return map[4*r +: 4];
        endfunction

        function automatic logic [7:0] seg_pattern(input logic [3:0] hex);
                logic [6:0] on;
                // gfedcba, active high before inversion
                case (hex)
                        4'h0:    on = 7'h3F;
                        4'h1:    on = 7'h06;
                        4'h2:    on = 7'h5B;
                        4'h3:    on = 7'h4F;
                        4'h4:    on = 7'h66;
                        4'h5:    on = 7'h6D;
                        4'h6:    on = 7'h7D;
                        4'h7:    on = 7'h07;
                        4'h8:    on = 7'h7F;
                        4'h9:    on = 7'h6F;
                        4'hA:    on = 7'h77;
                        4'hB:    on = 7'h7C;
                        4'hC:    on = 7'h39;
                        4'hD:    on = 7'h5E;
                        4'hE:    on = 7'h79;
                        default: on = 7'h71;
                endcase
                return {1'b1, ~on};
        endfunction

        // shift-add-3 over the 12 input bits
        function automatic logic [15:0] bin_to_bcd(input logic [11:0] bin);
                logic [15:0] bcd;
                bcd = '0;
                for (int i = 11; i >= 0; i--) begin
                        for (int j = 0; j < 4; j++) begin
                                if (bcd[4*j +: 4] > 4'd4)
                                        bcd[4*j +: 4] = bcd[4*j +: 4] + 4'd3;
                        end
                        bcd = {bcd[14:0], bin[i]};
                end
                return bcd;
        endfunction

endpackage

`default_nettype wire

/* design/tick_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tick_gen
        import keypad_display_pkg::*;
#(
        parameter int DIV_BIT = 0
) (
        input  logic  clk,
        input  logic  reset_p,
        output tick_t tick
);

        logic [DIV_WIDTH-1:0] count;
        // last value of the selected divider bit
        logic                 bit_q;

        always_ff @(posedge clk or posedge reset_p) begin
                if (reset_p) begin
                        count <= '0;
                        bit_q <= 1'b0;
                end else begin
                        count <= count + 1'b1;
                        bit_q <= count[DIV_BIT];
                end
        end

        // one-cycle pulses on each edge of the selected bit
        assign tick = '{rise: count[DIV_BIT] & ~bit_q, fall: ~count[DIV_BIT] & bit_q};

endmodule

`default_nettype wire

/* design/button_debounce.sv */
`timescale 1ns/100ps
`default_nettype none

module button_debounce
        import keypad_display_pkg::*;
(
        input  logic clk,
        input  logic reset_p,
        input  logic btn,
        output logic press
);

        tick_t tick;
        logic  level;
        logic  level_q;

        tick_gen #(
                .DIV_BIT(DEBOUNCE_DIV_BIT)
        ) sample_tick (
                .clk     (clk),
                .reset_p (reset_p),
                .tick    (tick)
        );

        // button is only looked at on sample ticks, so bounces in between are lost
        always_ff @(posedge clk or posedge reset_p) begin
                if (reset_p) begin
                        level   <= 1'b0;
                        level_q <= 1'b0;
                end else begin
                        if (tick.rise)
                                level <= btn;
                        level_q <= level;
                end
        end

        // rising edge of the debounced level
        assign press = level & ~level_q;

endmodule

`default_nettype wire

/* keypad/keypad_scanner.sv */
`timescale 1ns/100ps
`default_nettype none

module keypad_scanner
        import keypad_display_pkg::*;
(
        input  logic       clk,
        input  logic       reset_p,
        input  logic [3:0] row,
        output logic [3:0] col,
        output key_event_t key
);

        tick_t       tick;
        scan_state_t state;
        scan_state_t next_state;
        logic [1:0]  col_idx;
        logic [1:0]  row_idx;

        tick_gen #(
                .DIV_BIT(SCAN_DIV_BIT)
        ) scan_tick (
                .clk     (clk),
                .reset_p (reset_p),
                .tick    (tick)
        );

        // state advances on the fall pulse, half a period after col was driven
        always_ff @(posedge clk or posedge reset_p) begin
                if (reset_p)
                        state <= SCAN0;
                else if (tick.fall)
                        state <= next_state;
        end

        always_comb begin
                case (state)
                        SCAN0:
                                next_state = (row == 4'b0000) ? SCAN1 : KEY_PROCESS;
                        SCAN1:
                                next_state = (row == 4'b0000) ? SCAN2 : KEY_PROCESS;
                        SCAN2:
                                next_state = (row == 4'b0000) ? SCAN3 : KEY_PROCESS;
                        SCAN3:
                                next_state = (row == 4'b0000) ? SCAN0 : KEY_PROCESS;
                        KEY_PROCESS:
                                next_state = (row == 4'b0000) ? SCAN0 : KEY_PROCESS;
                        default:
                                next_state = SCAN0;
                endcase
        end

        // index of the driven column
        always_comb begin
                case (col)
                        4'b0010: col_idx = 2'd1;
                        4'b0100: col_idx = 2'd2;
                        4'b1000: col_idx = 2'd3;
                        default: col_idx = 2'd0;
                endcase
        end

        // lowest pressed row wins
        always_comb begin
                if (row[0])
                        row_idx = 2'd0;
                else if (row[1])
                        row_idx = 2'd1;
                else if (row[2])
                        row_idx = 2'd2;
                else
                        row_idx = 2'd3;
        end

        // outputs follow the state on the rise pulse
        always_ff @(posedge clk or posedge reset_p) begin
                if (reset_p) begin
                        col <= 4'b0000;
                        key <= '0;
                end else if (tick.rise) begin
                        case (state)
                                SCAN0: begin
                                        col       <= 4'b0001;
                                        key.valid <= 1'b0;
                                end
                                SCAN1: begin
                                        col       <= 4'b0010;
                                        key.valid <= 1'b0;
                                end
                                SCAN2: begin
                                        col       <= 4'b0100;
                                        key.valid <= 1'b0;
                                end
                                SCAN3: begin
                                        col       <= 4'b1000;
                                        key.valid <= 1'b0;
                                end
                                KEY_PROCESS: begin
                                        // column stays put while the key is held
                                        key.valid <= 1'b1;
                                        if (row != 4'b0000)
                                                key.code <= key_code(col_idx, row_idx);
                                end
                                default: begin
                                        col       <= 4'b0000;
                                        key.valid <= 1'b0;
                                end
                        endcase
                end
        end

endmodule

`default_nettype wire

/* display/fnd_driver.sv */
`timescale 1ns/100ps
`default_nettype none

module fnd_driver
        import keypad_display_pkg::*;
(
        input  logic        clk,
        input  logic        reset_p,
        input  logic [15:0] value,
        input  logic        decimal,
        output fnd_t        fnd
);

        tick_t       tick;
        logic [3:0]  com_q;
        logic [3:0]  digit;
        logic [15:0] shown;

        tick_gen #(
                .DIV_BIT(DIGIT_DIV_BIT)
        ) digit_tick (
                .clk     (clk),
                .reset_p (reset_p),
                .tick    (tick)
        );

        // decimal mode only covers the low 12 bits of the entry
        assign shown = decimal ? bin_to_bcd(value[11:0]) : value;

        // one digit enabled at a time, moving left on each tick
        always_ff @(posedge clk or posedge reset_p) begin
                if (reset_p)
                        com_q <= 4'b1110;
                else if (tick.rise)
                        com_q <= {com_q[2:0], com_q[3]};
        end

        // digit lags com by one cycle
        always_ff @(posedge clk or posedge reset_p) begin
                if (reset_p) begin
                        digit <= 4'h0;
                end else begin
                        case (com_q)
                                4'b1110: digit <= shown[3:0];
                                4'b1101: digit <= shown[7:4];
                                4'b1011: digit <= shown[11:8];
                                4'b0111: digit <= shown[15:12];
                                default: digit <= 4'h0;
                        endcase
                end
        end

        assign fnd = '{com: com_q, seg: seg_pattern(digit)};

endmodule

`default_nettype wire

/* design/keypad_display_top.sv */
`timescale 1ns/100ps
`default_nettype none

module keypad_display_top
        import keypad_display_pkg::*;
(
        input  logic       clk,
        input  logic       reset_p,
        input  logic [3:0] row,
        input  logic       btn,
        output logic [3:0] col,
        output fnd_t       fnd,
        output key_event_t key
);

        logic        press;
        logic        decimal;
        logic        valid_q;
        logic        key_rise;
        logic [15:0] entry;

        keypad_scanner scanner0 (
                .clk     (clk),
                .reset_p (reset_p),
                .row     (row),
                .col     (col),
                .key     (key)
        );

        button_debounce debounce0 (
                .clk     (clk),
                .reset_p (reset_p),
                .btn     (btn),
                .press   (press)
        );

        fnd_driver fnd0 (
                .clk     (clk),
                .reset_p (reset_p),
                .value   (entry),
                .decimal (decimal),
                .fnd     (fnd)
        );

        // a held key keeps valid high, only its first cycle counts
        assign key_rise = key.valid & ~valid_q;

        // newest key lands in the low digit
        always_ff @(posedge clk or posedge reset_p) begin
                if (reset_p) begin
                        valid_q <= 1'b0;
                        entry   <= 16'h0000;
                end else begin
                        valid_q <= key.valid;
                        if (key_rise)
                                entry <= {entry[11:0], key.code};
                end
        end

        // hex after reset, each button press flips the mode
        always_ff @(posedge clk or posedge reset_p) begin
                if (reset_p)
                        decimal <= 1'b0;
                else if (press)
                        decimal <= ~decimal;
        end

endmodule

`default_nettype wire

/* dv/keypad_display_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module keypad_display_assertions #(
        parameter bit DIGIT_SIDE = 1'b0
) (
        input  logic       clk,
        input  logic       reset_p,
        input  logic [3:0] lines,
        input  logic       valid,
        input  logic       rise
);

        generate
                if (DIGIT_SIDE) begin : g_digit
                        // active-low enables, one digit lit at a time
                        com_one_low: assert property (@(posedge clk) disable iff (reset_p)
                                $onehot(~lines))
                                else $error("com %b does not have exactly one bit low", lines);
                end else begin : g_scan
                        col_onehot: assert property (@(posedge clk) disable iff (reset_p)
                                $onehot0(lines))
                                else $error("col %b drives more than one column", lines);
                        // valid only moves on the output phase of the scan
                        valid_on_rise: assert property (@(posedge clk) disable iff (reset_p)
                                $changed(valid) |-> $past(rise))
                                else $error("key valid changed outside a scan rise");
                end
        endgenerate

endmodule

bind keypad_scanner keypad_display_assertions #(.DIGIT_SIDE(1'b0)) scan_checks (
        .clk     (clk),
        .reset_p (reset_p),
        .lines   (col),
        .valid   (key.valid),
        .rise    (tick.rise)
);

bind fnd_driver keypad_display_assertions #(.DIGIT_SIDE(1'b1)) digit_checks (
        .clk     (clk),
        .reset_p (reset_p),
        .lines   (fnd.com),
        .valid   (1'b0),
        .rise    (1'b0)
);

`default_nettype wire

/* dv/keypad_display_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module keypad_display_tb
        import keypad_display_pkg::*;
();

        localparam logic ACT_KEY    = 1'b0;
        localparam logic ACT_BTN    = 1'b1;
        localparam int   STEPS      = 18;
        localparam int   WAIT_LIMIT = 200;

        // telephone layout, index is column * 4 + row
        localparam logic [3:0] KEY_CODES [16] = '{
                4'h7, 4'h4, 4'h1, 4'hC, 4'h8, 4'h5, 4'h2, 4'h0,
                4'h9, 4'h6, 4'h3, 4'hF, 4'hA, 4'hB, 4'hE, 4'hD
        };

        // active-low shapes for 0..F, dp g f e d c b a
        localparam logic [7:0] SHAPES [16] = '{
                8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
                8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
        };

        typedef struct packed {
                logic       act;
                logic [1:0] c;
                logic [1:0] r;
                logic [7:0] hold;
                logic [3:0] code;
                logic       dec;
        } step_t;

        logic        clk;
        logic        reset_p   = 1'b1;
        logic [3:0]  row       = 4'b0000;
        logic        btn       = 1'b0;
        logic [3:0]  col;
        fnd_t        fnd;
        key_event_t  key;

        logic        reset_req = 1'b1;
        logic        btn_req   = 1'b0;
        logic        held      = 1'b0;
        logic [1:0]  held_c    = 2'd0;
        logic [1:0]  held_r    = 2'd0;
        step_t       steps [STEPS];
        logic [15:0] lfsr      = 16'd69;
        logic [15:0] exp_entry = 16'h0000;
        logic        exp_dec   = 1'b0;
        int          errors    = 0;
        int          checks    = 0;
        int          cycles    = 0;
        int          limit     = 0;

        keypad_display_top dut0 (
                .clk     (clk),
                .reset_p (reset_p),
                .row     (row),
                .btn     (btn),
                .col     (col),
                .fnd     (fnd),
                .key     (key)
        );

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        // inputs follow the requests on the rising edge, row answers the driven column
        always @(posedge clk) begin
                reset_p <= reset_req;
                btn     <= btn_req;
                if (held && col[held_c])
                        row <= 4'b0001 << held_r;
                else
                        row <= 4'b0000;
        end

        function automatic logic [15:0] lfsr_next(input logic [15:0] s);
                if (s[0])
                        return (s >> 1) ^ 16'hB400;
                return s >> 1;
        endfunction

        task automatic take_bits(input int n, output int v);
                v = 0;
                for (int i = 0; i < n; i++) begin
                        v = v * 2 + int'(lfsr[0]);
                        lfsr = lfsr_next(lfsr);
                end
        endtask

        // expected digit at a position, hex nibble or decimal digit of bits 11:0
        function automatic logic [3:0] shown_digit(input logic [15:0] value, input logic dec,
                                                   input int pos);
                int v;
                int div;
                if (!dec)
                        return value[4*pos +: 4];
                v = int'(value[11:0]);
                div = 1;
                for (int i = 0; i < pos; i++)
                        div = div * 10;
                return 4'((v / div) % 10);
        endfunction

        task automatic check_value(input string name, input logic [15:0] got,
                                   input logic [15:0] want);
                checks++;
                if (got !== want) begin
                        $display("FAIL %s got %h expected %h", name, got, want);
                        errors++;
                end
        endtask

        task automatic wait_valid(input logic level, output bit seen);
                int n;
                n = 0;
                while (key.valid !== level && n < WAIT_LIMIT) begin
                        @(negedge clk);
                        n++;
                end
                seen = (key.valid === level);
        endtask

        task automatic check_scan_order();
                logic [3:0] prev;
                int seen;
                int n;
                prev = col;
                seen = 0;
                n = 0;
                while (seen < 5 && n < WAIT_LIMIT) begin
                        @(negedge clk);
                        n++;
                        if (col !== prev) begin
                                check_value("col", 16'(col), 16'(4'b0001 << (seen % 4)));
                                prev = col;
                                seen++;
                        end
                end
                if (seen < 5) begin
                        $display("column scan stopped after %0d changes", seen);
                        errors++;
                end
        endtask

        task automatic press_key(input step_t s);
                bit seen;
                held_c = s.c;
                held_r = s.r;
                held   = 1'b1;
                wait_valid(1'b1, seen);
                if (!seen) begin
                        $display("key at column %0d row %0d was never reported", s.c, s.r);
                        errors++;
                end else begin
                        check_value("key.code", 16'(key.code), 16'(s.code));
                end
                exp_entry = {exp_entry[11:0], s.code};
                repeat (s.hold) @(negedge clk);
                held = 1'b0;
                wait_valid(1'b0, seen);
                if (!seen) begin
                        $display("key.valid stayed high after the key was released");
                        errors++;
                end
        endtask

        task automatic push_button(input step_t s);
                btn_req = 1'b1;
                repeat (s.hold) @(negedge clk);
                btn_req = 1'b0;
                repeat (16) @(negedge clk);
                exp_dec = s.dec;
        endtask

        // each digit checked in the middle of a fresh com window
        task automatic check_display();
                logic [3:0] want_com;
                int n;
                for (int pos = 0; pos < 4; pos++) begin
                        want_com = ~(4'b0001 << pos);
                        n = 0;
                        while (fnd.com === want_com && n < WAIT_LIMIT) begin
                                @(negedge clk);
                                n++;
                        end
                        while (fnd.com !== want_com && n < WAIT_LIMIT) begin
                                @(negedge clk);
                                n++;
                        end
                        if (n >= WAIT_LIMIT) begin
                                $display("digit %0d was never enabled", pos);
                                errors++;
                        end
                        repeat (16) @(negedge clk);
                        check_value("fnd.com", 16'(fnd.com), 16'(want_com));
                        check_value("fnd.seg", 16'(fnd.seg),
                                    16'(SHAPES[shown_digit(exp_entry, exp_dec, pos)]));
                end
        endtask

        initial begin
                step_t tmp;
                int j;
                for (int k = 0; k < 16; k++)
                        steps[k] = '{act: ACT_KEY, c: 2'(k / 4), r: 2'(k % 4), hold: 8'd30,
                                     code: KEY_CODES[k], dec: 1'b0};
                steps[16] = '{act: ACT_BTN, c: 2'd0, r: 2'd0, hold: 8'd24, code: 4'h0, dec: 1'b1};
                steps[17] = '{act: ACT_BTN, c: 2'd0, r: 2'd0, hold: 8'd24, code: 4'h0, dec: 1'b0};
                // random order of the 16 keys
                for (int i = 15; i > 0; i--) begin
                        take_bits(5, j);
                        j = j % (i + 1);
                        tmp = steps[i];
                        steps[i] = steps[j];
                        steps[j] = tmp;
                end
                // each row may wait for a press, a release and a display sweep
                j = 400;
                for (int i = 0; i < STEPS; i++)
                        j += int'(steps[i].hold) + 3 * WAIT_LIMIT;
                limit = 2 * j;

                repeat (16) @(negedge clk);
                reset_req = 1'b0;
                @(negedge clk);
                check_value("col", 16'(col), 16'h0000);
                check_value("key.valid", 16'(key.valid), 16'h0000);
                check_value("key.code", 16'(key.code), 16'h0000);
                check_value("fnd.com", 16'(fnd.com), 16'h000E);
                check_value("fnd.seg", 16'(fnd.seg), 16'(SHAPES[0]));
                check_scan_order();

                for (int i = 0; i < STEPS; i++) begin
                        if (steps[i].act == ACT_KEY) begin
                                press_key(steps[i]);
                        end else begin
                                push_button(steps[i]);
                                check_display();
                        end
                        if (i == 15)
                                check_display();
                end

                $display("checks: %0d  errors: %0d", checks, errors);
                if (errors == 0)
                        $display("Verification passed");
                else
                        $display("Verification failed");
                $finish;
        end

        initial begin
                wait (limit > 0);
                while (cycles < limit) begin
                        @(posedge clk);
                        cycles++;
                end
                $display("run stopped after %0d cycles without finishing", cycles);
                $display("checks: %0d  errors: %0d", checks, errors + 1);
                $display("Verification failed");
                $finish;
        end

endmodule

`default_nettype wire

/* keypad_display.f */
common/keypad_display_pkg.sv
design/tick_gen.sv
design/button_debounce.sv
keypad/keypad_scanner.sv
display/fnd_driver.sv
design/keypad_display_top.sv
dv/keypad_display_assertions.sv
dv/keypad_display_tb.sv

/* Makefile */
# Verilator simulation of the keypad display panel

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, pass or fail taken from sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module keypad_display_tb \
		-f keypad_display.f -Mdir obj_dir -o keypad_display_sim
	./obj_dir/keypad_display_sim | tee sim.log
	@grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
